//--- compile.f
source/vdma_pkg.sv
source/pixel_packer.sv
source/word_fifo.sv
source/idle_timer.sv
source/burst_fsm.sv
source/frame_writer.sv
tb/axi_mem_slave.sv
tb/frame_writer_tb.sv

//--- tb/frame_writer_tb.sv
/*
 * frame writer testbench
 * streams pixel lines through the writer into a memory model and checks
 * memory contents and burst shapes against a reference packing
 */
`timescale 1ns/1ps
module frame_writer_tb;
    import vdma_pkg::*;

    // defaults of frame_writer
    localparam int BURST_LEN = 8;
    localparam int IDLE_LIMIT = 16;
    localparam int FRAME_BASE = 0;
    // full, padded, back-pressure and flush tests
    localparam int TOTAL_PIX = 4 * 64 + (13 + 3 + 13 + 3) + 8 * 64 + 20;
    localparam int TIMEOUT_CYCLES = TOTAL_PIX * 20 + 2000;

    logic       mm_tras_inst;
    logic       reset;
    pixel_t     pix_data;
    logic       pix_eol;
    logic       pix_valid;
    logic       pix_ready;
    addr_t      aw_addr;
    len_t       aw_len;
    logic       aw_valid;
    logic       aw_ready;
    word_t      w_data;
    logic       w_last;
    logic       w_valid;
    logic       w_ready;
    logic       b_valid;
    logic [1:0] b_resp;
    logic       b_ready;
    logic       bp_en;

    integer seed;
    // stimulus in send order, reference words in memory order
    pixel_t line_pix [TOTAL_PIX];
    logic   line_eol [TOTAL_PIX];
    word_t  exp_words [TOTAL_PIX];
    int     n_pix;
    int     pix_sent;
    int     n_exp;
    logic   stall_seen;

    always #2 mm_tras_inst = ~mm_tras_inst;

    frame_writer dut (
        .mm_tras_inst (mm_tras_inst),
        .reset        (reset),
        .pix_data     (pix_data),
        .pix_eol      (pix_eol),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .aw_addr      (aw_addr),
        .aw_len       (aw_len),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .w_data       (w_data),
        .w_last       (w_last),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .b_valid      (b_valid),
        .b_resp       (b_resp),
        .b_ready      (b_ready)
    );

    axi_mem_slave mem_slave (
        .mm_tras_inst (mm_tras_inst),
        .reset        (reset),
        .bp_en        (bp_en),
        .aw_addr      (aw_addr),
        .aw_len       (aw_len),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .w_data       (w_data),
        .w_last       (w_last),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .b_valid      (b_valid),
        .b_resp       (b_resp),
        .b_ready      (b_ready)
    );

    // eight lanes per word, pixel 0 lowest, word closed early at eol
    function automatic int pack_reference(input int first, input int count, input int out_idx);
        word_t acc;
        int    lane;
        int    n_out;
        int    i;
        acc = '0;
        lane = 0;
        n_out = 0;
        for (i = first; i < first + count; i++) begin
            acc[lane*PIX_W +: PIX_W] = line_pix[i];
            if (line_eol[i] || lane == LANES - 1) begin
                exp_words[out_idx + n_out] = acc;
                n_out++;
                // unused lanes stay zero
                acc = '0;
                lane = 0;
            end else begin
                lane++;
            end
        end
        return n_out;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic add_line(input int len);
        int i;
        for (i = 0; i < len; i++) begin
            line_pix[n_pix] = $random(seed);
            line_eol[n_pix] = (i == len - 1);
            n_pix++;
        end
    endtask

    // entered 1 ns after an edge, pixel held until the packer takes it
    task automatic drive_pixels();
        logic ready_seen;
        while (pix_sent < n_pix) begin
            pix_data = line_pix[pix_sent];
            pix_eol = line_eol[pix_sent];
            pix_valid = 1'b1;
            // mid-cycle look at ready, which is registered-only
            #2;
            ready_seen = pix_ready;
            if (!ready_seen) begin
                stall_seen = 1'b1;
            end
            @(posedge mm_tras_inst);
            #1;
            if (ready_seen) begin
                pix_sent++;
            end
        end
        pix_valid = 1'b0;
        pix_eol = 1'b0;
    endtask

    // address steps by whole bursts, beats match aw_len
    task automatic check_bursts(input string name);
        int k;
        int words_before;
        words_before = 0;
        for (k = 0; k < mem_slave.burst_cnt; k++) begin
            check_value($sformatf("%s burst %0d len", name, k), 1,
                        mem_slave.burst_len[k] < BURST_LEN);
            check_value($sformatf("%s burst %0d beats", name, k),
                        mem_slave.burst_len[k] + 1, mem_slave.burst_beats[k]);
            check_value($sformatf("%s burst %0d addr", name, k),
                        FRAME_BASE + BYTES_PER_WORD * words_before, mem_slave.burst_addr[k]);
            words_before += mem_slave.burst_beats[k];
        end
    endtask

    // send queued lines, wait for memory, compare this test's words
    task automatic run_test(input string name);
        int first_pix;
        int first_word;
        int i;
        first_pix = pix_sent;
        first_word = n_exp;
        drive_pixels();
        n_exp = first_word + pack_reference(first_pix, n_pix - first_pix, first_word);
        while (mem_slave.word_cnt < n_exp) begin
            @(posedge mm_tras_inst);
            #1;
        end
        // quiet period exposes any extra beats
        repeat (IDLE_LIMIT * 2) @(posedge mm_tras_inst);
        #1;
        check_value($sformatf("%s word count", name), n_exp, mem_slave.word_cnt);
        for (i = first_word; i < n_exp; i++) begin
            check_value($sformatf("%s word %0d", name, i), exp_words[i],
                        mem_slave.mem[FRAME_BASE / BYTES_PER_WORD + i]);
        end
        check_bursts(name);
    endtask

    initial begin
        seed = 43387;
        mm_tras_inst = 1'b0;
        reset = 1'b1;
        pix_data = '0;
        pix_eol = 1'b0;
        pix_valid = 1'b0;
        bp_en = 1'b0;
        n_pix = 0;
        pix_sent = 0;
        n_exp = 0;
        stall_seen = 1'b0;
        repeat (4) @(posedge mm_tras_inst);
        #1;
        reset = 1'b0;

        repeat (4) add_line(64);
        run_test("full lines");

        add_line(13);
        add_line(3);
        add_line(13);
        add_line(3);
        run_test("padded lines");

        // long stalls must back up into the pixel port
        bp_en = 1'b1;
        stall_seen = 1'b0;
        repeat (8) add_line(64);
        run_test("random backpressure");
        check_value("backpressure stall", 1, stall_seen);
        bp_en = 1'b0;

        // tail leaves only through the idle flush
        add_line(20);
        run_test("short burst flush");
        check_value("short burst flush last len", (20 + LANES - 1) / LANES - 1,
                    mem_slave.burst_len[mem_slave.burst_cnt - 1]);

        $display("All tests passed");
        $finish;
    end

    // bound on total run length
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge mm_tras_inst);
        $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- tb/axi_mem_slave.sv
/*
 * axi write memory model
 * takes one burst at a time into a word array, with optional random
 * back-pressure on address, data and response, and logs every burst
 */
`timescale 1ns/1ps
module axi_mem_slave #(
    parameter int SEED      = 43387,
    parameter int MEM_WORDS = 1024
) (
    input  logic            mm_tras_inst,
    input  logic            reset,
    input  logic            bp_en,
    input  vdma_pkg::addr_t aw_addr,
    input  vdma_pkg::len_t  aw_len,
    input  logic            aw_valid,
    output logic            aw_ready,
    input  vdma_pkg::word_t w_data,
    input  logic            w_last,
    input  logic            w_valid,
    output logic            w_ready,
    output logic            b_valid,
    output logic [1:0]      b_resp,
    input  logic            b_ready
);
    import vdma_pkg::*;

    word_t  mem [MEM_WORDS];
    // one entry per accepted address
    addr_t  burst_addr [256];
    len_t   burst_len [256];
    int     burst_beats [256];
    int     burst_cnt;
    int     word_cnt;
    integer seed;
    // 0 address, 1 data, 2 response
    int     phase;
    int     base_word;
    int     beat;
    logic   bp_now;
    logic   in_reset;

    // ready odds of one in sixteen under back-pressure
    function automatic logic roll();
        if (!bp_now) begin
            return 1'b1;
        end
        return ($random(seed) & 15) == 0;
    endfunction

    initial begin
        seed = SEED;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        b_resp = 2'b00;
        phase = 0;
        burst_cnt = 0;
        word_cnt = 0;
        base_word = 0;
        beat = 0;
    end

    always @(posedge mm_tras_inst) begin
        // controls taken at the edge, outputs moved 1 ns later
        bp_now = bp_en;
        in_reset = reset;
        if (in_reset) begin
            phase = 0;
        end else begin
            case (phase)
                0: begin
                    if (aw_valid && aw_ready) begin
                        burst_addr[burst_cnt] = aw_addr;
                        burst_len[burst_cnt] = aw_len;
                        base_word = int'(aw_addr) / BYTES_PER_WORD;
                        beat = 0;
                        phase = 1;
                    end
                end
                1: begin
                    if (w_valid && w_ready) begin
                        mem[(base_word + beat) % MEM_WORDS] = w_data;
                        beat++;
                        word_cnt++;
                        // burst length as the master marked it
                        if (w_last) begin
                            burst_beats[burst_cnt] = beat;
                            burst_cnt++;
                            phase = 2;
                        end
                    end
                end
                default: begin
                    if (b_valid && b_ready) begin
                        phase = 0;
                    end
                end
            endcase
        end
        #1;
        aw_ready = !in_reset && phase == 0 && roll();
        w_ready = !in_reset && phase == 1 && roll();
        // response held once raised
        if (phase == 2) begin
            if (!b_valid) begin
                b_valid = roll();
            end
        end else begin
            b_valid = 1'b0;
        end
    end

endmodule

//--- source/frame_writer.sv
/*
 * frame writer
 * packs a pixel stream into 256-bit words and writes them to memory
 * in bursts; packer, word fifo, idle timer and burst sequencer
 */
`timescale 1ns/1ps
module frame_writer #(
    parameter int              BURST_LEN  = 8,
    parameter int              FIFO_DEPTH = 32,
    parameter int              IDLE_LIMIT = 16,
    parameter vdma_pkg::addr_t FRAME_BASE = '0
) (
    input  logic             mm_tras_inst,
    input  logic             reset,
    // pixel stream
    input  vdma_pkg::pixel_t pix_data,
    input  logic             pix_eol,
    input  logic             pix_valid,
    output logic             pix_ready,
    // memory write port
    output vdma_pkg::addr_t  aw_addr,
    output vdma_pkg::len_t   aw_len,
    output logic             aw_valid,
    input  logic             aw_ready,
    output vdma_pkg::word_t  w_data,
    output logic             w_last,
    output logic             w_valid,
    input  logic             w_ready,
    input  logic             b_valid,
    input  logic [1:0]       b_resp,
    output logic             b_ready
);
    import vdma_pkg::*;

    // packer to fifo
    word_t  word_data;
    logic   word_valid;
    logic   word_ready;
    // fifo to sequencer
    word_t  head_data;
    count_t word_count;
    logic   pop;
    // pause detection
    logic   pix_fire;
    logic   flush_req;

    pixel_packer u_packer (
        .mm_tras_inst (mm_tras_inst),
        .reset        (reset),
        .pix_data     (pix_data),
        .pix_eol      (pix_eol),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .pix_fire     (pix_fire),
        .word_data    (word_data),
        .word_valid   (word_valid),
        .word_ready   (word_ready)
    );

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .mm_tras_inst (mm_tras_inst),
        .reset        (reset),
        .word_data    (word_data),
        .word_valid   (word_valid),
        .word_ready   (word_ready),
        .pop          (pop),
        .head_data    (head_data),
        .word_count   (word_count)
    );

    idle_timer #(
        .IDLE_LIMIT (IDLE_LIMIT)
    ) u_timer (
        .mm_tras_inst (mm_tras_inst),
        .reset        (reset),
        .pix_fire     (pix_fire),
        .flush_req    (flush_req)
    );

    burst_fsm #(
        .BURST_LEN  (BURST_LEN),
        .FRAME_BASE (FRAME_BASE)
    ) u_burst (
        .mm_tras_inst (mm_tras_inst),
        .reset        (reset),
        .word_count   (word_count),
        .head_data    (head_data),
        .flush_req    (flush_req),
        .pop          (pop),
        .aw_addr      (aw_addr),
        .aw_len       (aw_len),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .w_data       (w_data),
        .w_last       (w_last),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .b_valid      (b_valid),
        .b_resp       (b_resp),
        .b_ready      (b_ready)
    );

endmodule

//--- source/burst_fsm.sv
/*
 * burst sequencer
 * issues write bursts from the word fifo, full length when enough words
 * are queued, shorter on a flush request, and tracks the write address
 */
`timescale 1ns/1ps
module burst_fsm #(
    parameter int              BURST_LEN  = 8,
    parameter vdma_pkg::addr_t FRAME_BASE = '0
) (
    input  logic             mm_tras_inst,
    input  logic             reset,
    input  vdma_pkg::count_t word_count,
    input  vdma_pkg::word_t  head_data,
    input  logic             flush_req,
    output logic             pop,
    output vdma_pkg::addr_t  aw_addr,
    output vdma_pkg::len_t   aw_len,
    output logic             aw_valid,
    input  logic             aw_ready,
    output vdma_pkg::word_t  w_data,
    output logic             w_last,
    output logic             w_valid,
    input  logic             w_ready,
    input  logic             b_valid,
    input  logic [1:0]       b_resp,
    output logic             b_ready
);
    import vdma_pkg::*;

    burst_state_t state;
    // running write address
    addr_t        addr_q;
    // latched beats minus one for the current burst
    len_t         len_q;
    // beats already sent in this burst
    len_t         beat_cnt;
    count_t       start_beats;
    logic         start_full;
    logic         start_flush;
    addr_t        burst_bytes;

    // start conditions seen from idle
    assign start_full = word_count >= count_t'(BURST_LEN);
    assign start_flush = flush_req && word_count != '0;
    // short burst takes whatever is queued
    assign start_beats = start_full ? count_t'(BURST_LEN) : word_count;
    assign burst_bytes = (addr_t'(len_q) + addr_t'(1)) * addr_t'(BYTES_PER_WORD);

    // channel outputs follow the state directly
    assign aw_valid = state == ADDR;
    assign aw_addr = addr_q;
    assign aw_len = len_q;
    assign w_valid = state == DATA;
    assign w_data = head_data;
    assign w_last = w_valid && beat_cnt == len_q;
    assign b_ready = state == RESP;
    // one fifo pop per accepted beat
    assign pop = w_valid && w_ready;

    always_ff @(posedge mm_tras_inst) begin
        if (reset) begin
            state <= IDLE;
            addr_q <= FRAME_BASE;
            len_q <= '0;
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_full || start_flush) begin
                        len_q <= len_t'(start_beats - count_t'(1));
                        beat_cnt <= '0;
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (aw_ready) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (pop) begin
                        if (w_last) begin
                            state <= RESP;
                        end else begin
                            beat_cnt <= beat_cnt + len_t'(1);
                        end
                    end
                end
                RESP: begin
                    // burst closed, step past its words
                    if (b_valid) begin
                        addr_q <= addr_q + burst_bytes;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // address request held until taken
    a_aw_hold: assert property (
        @(posedge mm_tras_inst) disable iff (reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(aw_len)
    );

    // nothing more on the data channel until the next address handshake
    a_last_is_final: assert property (
        @(posedge mm_tras_inst) disable iff (reset)
        pop && w_last |=> !w_valid throughout (aw_valid && aw_ready)[->1]
    );

    // memory is expected to answer okay
    a_resp_okay: assert property (
        @(posedge mm_tras_inst) disable iff (reset)
        b_valid && b_ready |-> b_resp == 2'b00
    );

endmodule

//--- source/idle_timer.sv
/*
 * idle timer
 * counts cycles without an accepted pixel and requests a flush of
 * the queued tail once the source has paused long enough
 */
`timescale 1ns/1ps
module idle_timer #(
    parameter int IDLE_LIMIT = 16
) (
    input  logic mm_tras_inst,
    input  logic reset,
    input  logic pix_fire,
    output logic flush_req
);

    localparam int CNT_W = $clog2(IDLE_LIMIT + 1);

    // quiet cycles since the last pixel, saturates at the limit
    logic [CNT_W-1:0] idle_cnt;

    assign flush_req = idle_cnt == CNT_W'(IDLE_LIMIT);

    always_ff @(posedge mm_tras_inst) begin
        if (reset) begin
            idle_cnt <= '0;
        end else if (pix_fire) begin
            idle_cnt <= '0;
        end else if (!flush_req) begin
            idle_cnt <= idle_cnt + CNT_W'(1);
        end
    end

endmodule

//--- source/word_fifo.sv
/*
 * word fifo
 * circular queue of packed words, head shown without read delay,
 * with an occupancy count for the burst sequencer
 */
`timescale 1ns/1ps
module word_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic             mm_tras_inst,
    input  logic             reset,
    input  vdma_pkg::word_t  word_data,
    input  logic             word_valid,
    output logic             word_ready,
    input  logic             pop,
    output vdma_pkg::word_t  head_data,
    output vdma_pkg::count_t word_count
);
    import vdma_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    // queued word storage
    word_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;

    // full means no room for the packer
    assign word_ready = word_count != count_t'(FIFO_DEPTH);
    assign push = word_valid && word_ready;
    assign head_data = mem[rd_ptr];

    // pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    always_ff @(posedge mm_tras_inst) begin
        if (push) begin
            mem[wr_ptr] <= word_data;
        end
    end

    always_ff @(posedge mm_tras_inst) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            word_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // count moves only when one side acts alone
            if (push && !pop) begin
                word_count <= word_count + count_t'(1);
            end else if (pop && !push) begin
                word_count <= word_count - count_t'(1);
            end
        end
    end

    // sequencer reads only words it has seen counted
    a_no_pop_empty: assert property (
        @(posedge mm_tras_inst) disable iff (reset)
        pop |-> word_count != '0
    );

    a_count_bound: assert property (
        @(posedge mm_tras_inst) disable iff (reset)
        word_count <= count_t'(FIFO_DEPTH)
    );

endmodule

//--- source/pixel_packer.sv
/*
 * pixel packer
 * gathers eight pixels per memory word, pixel 0 in the lowest lane,
 * and closes a word early at end of line with the unused lanes zeroed
 */
`timescale 1ns/1ps
module pixel_packer (
    input  logic             mm_tras_inst,
    input  logic             reset,
    input  vdma_pkg::pixel_t pix_data,
    input  logic             pix_eol,
    input  logic             pix_valid,
    output logic             pix_ready,
    output logic             pix_fire,
    output vdma_pkg::word_t  word_data,
    output logic             word_valid,
    input  logic             word_ready
);
    import vdma_pkg::*;

    localparam int IDX_W = $clog2(LANES);

    // lanes collected so far for the open word
    pixel_t           lane_q [LANES];
    // lane that the next pixel lands in
    logic [IDX_W-1:0] lane_idx;
    // open word with the incoming pixel merged in
    word_t            next_word;
    logic             word_done;

    // stall only while a finished word sits unaccepted
    assign pix_ready = !word_valid || word_ready;
    assign pix_fire = pix_valid && pix_ready;

    // word closes on the last lane or on eol
    assign word_done = pix_fire && (pix_eol || lane_idx == IDX_W'(LANES - 1));

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (i < int'(lane_idx)) begin
                next_word[i*PIX_W +: PIX_W] = lane_q[i];
            end else if (i == int'(lane_idx)) begin
                next_word[i*PIX_W +: PIX_W] = pix_data;
            end else begin
                // padding for short lines
                next_word[i*PIX_W +: PIX_W] = '0;
            end
        end
    end

    // lane and holding registers
    always_ff @(posedge mm_tras_inst) begin
        if (pix_fire) begin
            lane_q[lane_idx] <= pix_data;
        end
        if (word_done) begin
            word_data <= next_word;
        end
    end

    always_ff @(posedge mm_tras_inst) begin
        if (reset) begin
            lane_idx <= '0;
            word_valid <= 1'b0;
        end else begin
            if (pix_fire) begin
                lane_idx <= word_done ? '0 : lane_idx + IDX_W'(1);
            end
            // a new word can replace one leaving in the same cycle
            if (word_done) begin
                word_valid <= 1'b1;
            end else if (word_ready) begin
                word_valid <= 1'b0;
            end
        end
    end

    // offered word held until the fifo takes it
    a_word_stable: assert property (
        @(posedge mm_tras_inst) disable iff (reset)
        word_valid && !word_ready |=> word_valid && $stable(word_data)
    );

endmodule

//--- source/vdma_pkg.sv
/*
 * vdma package
 * widths, vector types and burst states shared by the frame writer blocks
 */
package vdma_pkg;

    // pixel and memory word geometry
    localparam int PIX_W = 32;
    localparam int WORD_W = 256;
    // pixels per memory word
    localparam int LANES = WORD_W / PIX_W;

    // memory side
    localparam int ADDR_W = 29;
    localparam int LEN_W = 8;
    // byte step between consecutive words
    localparam int BYTES_PER_WORD = WORD_W / 8;

    // one pixel from the video stream
    typedef logic [PIX_W-1:0] pixel_t;

    // one packed memory word, pixel 0 in bits 31:0
    typedef logic [WORD_W-1:0] word_t;

    // byte address on the write channel
    typedef logic [ADDR_W-1:0] addr_t;

    // burst length field, beats minus one
    typedef logic [LEN_W-1:0] len_t;

    // fifo occupancy, covers depths up to 32
    typedef logic [5:0] count_t;

    // write burst sequencing
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } burst_state_t;

endpackage
